//--- hdl/agu_pkg.sv
`default_nettype none

package agu_pkg;

   localparam int mem_addr_w = 10;
   localparam int period_w   = 6;
   localparam int data_w     = 16;
   localparam int mem_depth  = 2 ** mem_addr_w;

   typedef logic [mem_addr_w-1:0] mem_addr_t;
   typedef logic [period_w-1:0]   period_t;
   typedef logic [data_w-1:0]     data_t;
   typedef logic [2:0]            cfg_idx_t;

   // shift and incr are two's complement
   typedef struct packed {
      mem_addr_t iterations;
      period_t   period;
      period_t   duty;
      period_t   delay;
      mem_addr_t start;
      mem_addr_t shift;
      mem_addr_t incr;
   } agu_cfg_t;

   // register index map
   localparam cfg_idx_t cfg_iterations = 3'd0;
   localparam cfg_idx_t cfg_period     = 3'd1;
   localparam cfg_idx_t cfg_duty       = 3'd2;
   localparam cfg_idx_t cfg_delay      = 3'd3;
   localparam cfg_idx_t cfg_start      = 3'd4;
   localparam cfg_idx_t cfg_shift      = 3'd5;
   localparam cfg_idx_t cfg_incr       = 3'd6;

endpackage

`default_nettype wire

//--- hdl/agu_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module agu_cfg_regs import agu_pkg::*; (
   input  wire           clk,
   input  wire           rst,
   input  wire           cfg_we,
   input  wire cfg_idx_t cfg_idx,
   input  wire data_t    cfg_wdata,
   output agu_cfg_t      cfg
);

   // one field per write strobe, upper bits of the word dropped
   always_ff @(posedge clk) begin
      if (rst) begin
         cfg <= '0;
      end else if (cfg_we) begin
         case (cfg_idx)
            cfg_iterations: begin
               cfg.iterations <= cfg_wdata[mem_addr_w-1:0];
            end
            cfg_period: begin
               cfg.period <= cfg_wdata[period_w-1:0];
            end
            cfg_duty: begin
               cfg.duty <= cfg_wdata[period_w-1:0];
            end
            cfg_delay: begin
               cfg.delay <= cfg_wdata[period_w-1:0];
            end
            cfg_start: begin
               cfg.start <= cfg_wdata[mem_addr_w-1:0];
            end
            cfg_shift: begin
               cfg.shift <= cfg_wdata[mem_addr_w-1:0];  // signed
            end
            cfg_incr: begin
               cfg.incr <= cfg_wdata[mem_addr_w-1:0];   // signed
            end
            default: begin
               cfg <= cfg;  // index 7 unmapped
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- hdl/addr_gen.sv
`timescale 1ns/1ps
`default_nettype none

module addr_gen import agu_pkg::*; (
   input  wire           clk,
   input  wire           rst,
   input  wire           init,
   input  wire           run,
   input  wire           pause,
   input  wire agu_cfg_t cfg,
   output mem_addr_t     addr,
   output logic          mem_en,
   output logic          done
);

   typedef enum logic {idle_s, run_s} state_t;

   state_t                   state, state_nxt;
   logic signed [period_w:0] phase, phase_nxt;  // negative while in delay
   logic signed [period_w:0] ph;
   logic signed [period_w:0] per_s, duty_s, dly_s;
   mem_addr_t                ptr, ptr_nxt, p;   // address of the next access
   mem_addr_t                iter, iter_nxt, it;
   mem_addr_t                addr_nxt;
   logic                     mem_en_q, mem_en_nxt;
   logic                     done_nxt;
   logic                     rep_req;
   logic                     go, issue, wrap, at_end, restart;

   assign per_s  = $signed({1'b0, cfg.period});
   assign duty_s = $signed({1'b0, cfg.duty});
   assign dly_s  = $signed({1'b0, cfg.delay});

   // held access is shown once pause drops
   assign mem_en = mem_en_q & ~pause;

   always_comb begin
      // init folds into the same cycle so init and run may coincide
      ph = phase;
      p  = ptr;
      it = iter;
      if (state == idle_s && init) begin
         ph = -dly_s;
         p  = cfg.start;
         it = '0;
      end

      go      = (state == run_s) || run;
      issue   = go && (ph >= 0) && (ph < duty_s);
      wrap    = (ph == per_s - 1);
      at_end  = go && wrap && (it == cfg.iterations - 1'b1);
      restart = at_end && (run || rep_req);

      state_nxt  = state;
      phase_nxt  = ph;
      ptr_nxt    = p;
      iter_nxt   = it;
      addr_nxt   = addr;
      mem_en_nxt = 1'b0;
      done_nxt   = 1'b1;

      if (go) begin
         state_nxt  = run_s;
         done_nxt   = 1'b0;
         mem_en_nxt = issue;

         if (issue) begin
            addr_nxt = p;
            if (ph == duty_s - 1)
               ptr_nxt = p + cfg.incr + cfg.shift;  // period boundary
            else
               ptr_nxt = p + cfg.incr;
         end

         if (wrap) begin
            phase_nxt = '0;
            iter_nxt  = it + 1'b1;
         end else begin
            phase_nxt = ph + 1'b1;
         end

         if (at_end) begin
            ptr_nxt  = cfg.start;
            iter_nxt = '0;
            if (restart) begin
               phase_nxt = '0;  // no delay on a repeat pass
            end else begin
               phase_nxt = -dly_s;
               state_nxt = idle_s;
               done_nxt  = 1'b1;  // high right after the last period
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= idle_s;
         phase    <= '0;
         ptr      <= '0;
         iter     <= '0;
         addr     <= '0;
         mem_en_q <= 1'b0;
         done     <= 1'b1;
      end else if (!pause) begin
         state    <= state_nxt;
         phase    <= phase_nxt;
         ptr      <= ptr_nxt;
         iter     <= iter_nxt;
         addr     <= addr_nxt;
         mem_en_q <= mem_en_nxt;
         done     <= done_nxt;
      end
   end

   // run seen while frozen on the final cycle is kept for the restart
   always_ff @(posedge clk) begin
      if (rst)
         rep_req <= 1'b0;
      else if (at_end && !pause)
         rep_req <= 1'b0;
      else if (at_end && run && state == run_s)
         rep_req <= 1'b1;
   end

endmodule

`default_nettype wire

//--- hdl/data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem import agu_pkg::*; (
   input  wire            clk,
   input  wire            rst,
   input  wire            mem_we,
   input  wire mem_addr_t mem_waddr,
   input  wire data_t     mem_wdata,
   input  wire            rd_en,
   input  wire mem_addr_t rd_addr,
   output data_t          rd_data,
   output logic           rd_valid
);

   data_t mem [mem_depth];

   always_ff @(posedge clk) begin
      if (mem_we)
         mem[mem_waddr] <= mem_wdata;
      if (rd_en)
         rd_data <= mem[rd_addr];  // one cycle read latency
   end

   always_ff @(posedge clk) begin
      if (rst)
         rd_valid <= 1'b0;
      else
         rd_valid <= rd_en;
   end

endmodule

`default_nettype wire

//--- hdl/mem_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mem_unit import agu_pkg::*; (
   input  wire            clk,
   input  wire            rst,
   input  wire            cfg_we,
   input  wire cfg_idx_t  cfg_idx,
   input  wire data_t     cfg_wdata,
   input  wire            mem_we,
   input  wire mem_addr_t mem_waddr,
   input  wire data_t     mem_wdata,
   input  wire            init,
   input  wire            run,
   input  wire            pause,
   output data_t          rd_data,
   output logic           rd_valid,
   output logic           done
);

   agu_cfg_t  cfg;
   mem_addr_t addr;
   logic      mem_en;

   agu_cfg_regs i_cfg_regs (
      .clk       (clk),
      .rst       (rst),
      .cfg_we    (cfg_we),
      .cfg_idx   (cfg_idx),
      .cfg_wdata (cfg_wdata),
      .cfg       (cfg)
   );

   addr_gen i_addr_gen (
      .clk    (clk),
      .rst    (rst),
      .init   (init),
      .run    (run),
      .pause  (pause),
      .cfg    (cfg),
      .addr   (addr),
      .mem_en (mem_en),
      .done   (done)
   );

   // host preload on the write port, generator on the read port
   data_mem i_data_mem (
      .clk       (clk),
      .rst       (rst),
      .mem_we    (mem_we),
      .mem_waddr (mem_waddr),
      .mem_wdata (mem_wdata),
      .rd_en     (mem_en),
      .rd_addr   (addr),
      .rd_data   (rd_data),
      .rd_valid  (rd_valid)
   );

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;  // 10 ns period
   end

   // sync reset over the first three rising edges
   initial begin
      rst = 1'b1;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

`default_nettype wire

//--- verification/tb_mem_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_unit import agu_pkg::*; ();

   // walk tests 2 to 6
   localparam int n_tests = 5;
   localparam int t_it   [n_tests] = '{5, 4, 4, 3, 3};
   localparam int t_per  [n_tests] = '{4, 7, 7, 4, 4};
   localparam int t_duty [n_tests] = '{4, 3, 3, 2, 2};
   localparam int t_dly  [n_tests] = '{0, 5, 5, 3, 3};
   localparam int t_pass [n_tests] = '{1, 1, 1, 2, 1};

   typedef struct packed {
      int it;
      int per;
      int duty;
      int dly;
      int start;
      int shift;
      int incr;
      int pass;
      int len;
   } walk_t;

   logic      clk, rst;
   logic      cfg_we, mem_we, init, run, pause;
   cfg_idx_t  cfg_idx;
   data_t     cfg_wdata, mem_wdata, rd_data;
   mem_addr_t mem_waddr;
   logic      rd_valid, done;

   data_t     mem_copy [mem_depth];
   data_t     exp_arr  [256];
   walk_t     m;                    // model of the loaded walk
   int        exp_cnt, err_cnt, run_t0, wcyc;
   int        rd_idx  = 0;
   int        clk_cnt = 0;
   logic      idx_clr, timed;
   logic      exp_valid, exp_done;

   tb_clk_gen i_clk_gen (.clk(clk), .rst(rst));

   mem_unit i_dut (.*);

   function automatic int addr_of(walk_t w, int i, int j);
      return (w.start + i * (w.duty * w.incr + w.shift) + j * w.incr) & (mem_depth - 1);
   endfunction

   // c counts from the run cycle
   function automatic logic valid_at(walk_t w, int c);
      int k;
      k = c - 2 - w.dly;  // mem_en one cycle later, read data one more
      return k >= 0 && k < w.len - w.dly && (k % w.per) < w.duty;
   endfunction

   function automatic logic done_at(walk_t w, int c);
      return c < 1 || c >= w.len;
   endfunction

   assign wcyc      = clk_cnt - run_t0;
   assign exp_valid = valid_at(m, wcyc);
   assign exp_done  = done_at(m, wcyc);

   always @(posedge clk) begin
      clk_cnt <= clk_cnt + 1;
      if (idx_clr)
         rd_idx <= 0;
      else if (rd_valid)
         rd_idx <= rd_idx + 1;
   end

   a_rd_data: assert property (@(posedge clk) disable iff (rst)
      rd_valid |-> rd_idx < exp_cnt && rd_data == exp_arr[rd_idx])
      else begin
         $display("CHECK FAILED at %0t: read %0d gave %h, expected %h of %0d reads",
                  $time, rd_idx, rd_data, exp_arr[rd_idx], exp_cnt);
         err_cnt++;
      end

   a_valid_timing: assert property (@(posedge clk) disable iff (rst)
      timed |-> rd_valid == exp_valid)
      else begin
         $display("CHECK FAILED at %0t: rd_valid %b in walk cycle %0d", $time, rd_valid, wcyc);
         err_cnt++;
      end

   a_done_timing: assert property (@(posedge clk) disable iff (rst)
      timed |-> done == exp_done)
      else begin
         $display("CHECK FAILED at %0t: done %b in walk cycle %0d", $time, done, wcyc);
         err_cnt++;
      end

   task automatic stop_run(string why);
      $display("%s", why);
      $display("TEST FAIL");
      $finish;
   endtask

   task automatic write_cfg(cfg_idx_t idx, int value);
      cfg_we    <= 1'b1;
      cfg_idx   <= idx;
      cfg_wdata <= data_t'(value);
      @(posedge clk);
      cfg_we    <= 1'b0;
   endtask

   task automatic load_walk(int k, int start, int incr, int shift);
      m.it    = t_it[k];
      m.per   = t_per[k];
      m.duty  = t_duty[k];
      m.dly   = t_dly[k];
      m.start = start;
      m.shift = shift;
      m.incr  = incr;
      m.pass  = t_pass[k];
      m.len   = t_dly[k] + t_pass[k] * t_it[k] * t_per[k];
      write_cfg(cfg_iterations, m.it);
      write_cfg(cfg_period, m.per);
      write_cfg(cfg_duty, m.duty);
      write_cfg(cfg_delay, m.dly);
      write_cfg(cfg_start, m.start);
      write_cfg(cfg_shift, m.shift);
      write_cfg(cfg_incr, m.incr);
   endtask

   task automatic do_walk(bit use_pause);
      int c, hold_lo, hold_hi;
      hold_lo = m.dly + (m.it - 1) * m.per;  // last period of the first pass
      hold_hi = m.dly + m.it * m.per;
      exp_cnt = 0;
      for (int p = 0; p < m.pass; p++)
         for (int i = 0; i < m.it; i++)
            for (int j = 0; j < m.duty; j++) begin
               exp_arr[exp_cnt] = mem_copy[addr_of(m, i, j)];
               exp_cnt++;
            end
      idx_clr <= 1'b1;
      init    <= 1'b1;
      @(posedge clk);
      idx_clr <= 1'b0;
      init    <= 1'b0;
      timed   <= !use_pause;
      run_t0  <= clk_cnt + 1;
      c = 0;
      while (!(c >= 2 && done)) begin
         run   <= c == 0 || (m.pass > 1 && c >= hold_lo && c < hold_hi);
         pause <= use_pause && c > 0 && $urandom % 3 == 0;
         @(posedge clk);
         c++;
      end
      run   <= 1'b0;
      pause <= 1'b0;
      repeat (4) @(posedge clk);  // last read drains
      timed <= 1'b0;
      assert (rd_idx == exp_cnt)
         else begin
            $display("CHECK FAILED at %0t: %0d reads, expected %0d", $time, rd_idx, exp_cnt);
            err_cnt++;
         end
      @(posedge clk);
   endtask

   task automatic report(int n, string name, int errs_before);
      $display("test %0d %-24s %s", n, name, err_cnt == errs_before ? "ok" : "errors");
   endtask

   initial begin
      longint cycles;
      cycles = 0;
      for (int k = 0; k < n_tests; k++)
         cycles += t_dly[k] + t_pass[k] * t_it[k] * t_per[k];
      cycles = 4 * cycles + mem_depth + 40 * (n_tests + 1);  // plus preload and setup
      #(cycles * 10);
      stop_run("watchdog expired before the tests finished");
   end

   initial begin
      int e, shift;
      cfg_we    = 1'b0;
      cfg_idx   = '0;
      cfg_wdata = '0;
      mem_we    = 1'b0;
      mem_waddr = '0;
      mem_wdata = '0;
      init      = 1'b0;
      run       = 1'b0;
      pause     = 1'b0;
      idx_clr   = 1'b0;
      timed     = 1'b0;
      run_t0    = 0;
      exp_cnt   = 0;
      err_cnt   = 0;
      m         = '0;
      void'($urandom(32'hf7c2));
      @(posedge clk);
      while (rst)
         @(posedge clk);

      e = err_cnt;
      assert (done && !rd_valid)
         else begin
            $display("CHECK FAILED at %0t: after reset done %b rd_valid %b", $time, done, rd_valid);
            err_cnt++;
         end
      // preload; no read may show while idle
      for (int a = 0; a < mem_depth; a++) begin
         mem_copy[a] = data_t'($urandom);
         mem_we    <= 1'b1;
         mem_waddr <= mem_addr_t'(a);
         mem_wdata <= mem_copy[a];
         @(posedge clk);
      end
      mem_we <= 1'b0;
      report(1, "reset and idle", e);

      e = err_cnt;
      load_walk(0, 'h3f0, 3, 7);  // wraps past the top address
      do_walk(1'b0);
      report(2, "dense walk", e);

      e = err_cnt;
      shift = int'($urandom % 1024) - 512;
      load_walk(1, 'h200, -2, shift);
      do_walk(1'b0);
      report(3, "sparse walk", e);

      e = err_cnt;
      do_walk(1'b1);  // same walk as test 3
      report(4, "pause", e);

      e = err_cnt;
      load_walk(3, 'h050, 1, 4);
      do_walk(1'b0);
      report(5, "repeat run", e);

      e = err_cnt;
      m.pass  = t_pass[4];
      m.len   = t_dly[4] + t_pass[4] * t_it[4] * t_per[4];
      m.start = 'h123;
      write_cfg(cfg_start, m.start);
      do_walk(1'b0);
      report(6, "start rewritten", e);

      $display("%0d tests run, %0d checks failed", n_tests + 1, err_cnt);
      if (err_cnt == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
hdl/agu_pkg.sv
hdl/agu_cfg_regs.sv
hdl/addr_gen.sv
hdl/data_mem.sv
hdl/mem_unit.sv
verification/tb_clk_gen.sv
verification/tb_mem_unit.sv

//--- run_sim.sh
#!/bin/sh
# build and run the mem_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_mem_unit -f list.f; then
   echo "verilator build failed"
   exit 1
fi

if ! ./obj_dir/Vtb_mem_unit > "$log" 2>&1; then
   cat "$log"
   echo "simulation exited with an error"
   exit 1
fi

cat "$log"

if grep -q "TEST FAIL" "$log"; then
   exit 1
fi

exit 0
